//--- logic/gac_config.svh
// build-time constants; FIFO almost-full levels must stay below their depths
`ifndef GAC_CONFIG_SVH
`define GAC_CONFIG_SVH

// ******************************
// data path widths
// ******************************
`define GAC_PKT_W 134 // 6 bit flags + 128 bit word
`define GAC_MD_W 256

// fifo sizing
`define GAC_PKT_DEPTH 1024
`define GAC_MD_DEPTH 256
`define GAC_PKT_ALF_LEVEL 512 // half full
`define GAC_MD_ALF_LEVEL 250 // leaves room for in-flight records

// ******************************
// module ids
// ******************************
`define GAC_LMID 4 // this stage
`define GAC_NMID 5 // next stage in the pipeline
`define GAC_PASS_MID 6 // cpu sourced packets without an action

`endif

//--- logic/gac_pkg.sv
// field positions follow the switch header layout; metadata reuses the packet header positions
`include "gac_config.svh"

package gac_pkg;

	typedef logic [`GAC_PKT_W-1:0] pkt_word_t;
	typedef logic [`GAC_MD_W-1:0] md_t;
	typedef logic [31:0] act_word_t;
	typedef logic [7:0] tbl_addr_t;
	typedef logic [5:0] cpuid_t; // thread id or port
	typedef logic [7:0] mid_t;
	typedef logic [31:0] count_t;

	// packet word
	localparam int TAG_HI = 133;
	localparam int TAG_LO = 132;
	localparam logic [1:0] TAG_HEAD = 2'b01;
	localparam logic [1:0] TAG_MID = 2'b11;
	localparam logic [1:0] TAG_TAIL = 2'b10;
	localparam int FLG_HI = 133;
	localparam int FLG_LO = 128;
	localparam int PKT_SRC = 127;
	localparam int PKT_DST = 126;
	localparam int INPORT_HI = 125;
	localparam int INPORT_LO = 120;
	localparam int OUT_TYPE_HI = 119;
	localparam int OUT_TYPE_LO = 118;
	localparam int OUT_PORT_HI = 117;
	localparam int OUT_PORT_LO = 112;
	localparam int PRI_HI = 111;
	localparam int PRI_LO = 109;
	localparam int DISCARD = 108;
	localparam int MID_HI = 87; // also the metadata destination
	localparam int MID_LO = 80;
	localparam int CPU_SRC = 50;

	// metadata index, action word
	localparam int MD_IDX_HI = 57;
	localparam int MD_IDX_LO = 50;
	localparam int ACT_TYPE_HI = 31;
	localparam int ACT_TYPE_LO = 28;
	localparam int ACT_PORT_HI = 5;
	localparam int ACT_PORT_LO = 0;
	localparam int ACT_MID_HI = 7;
	localparam int ACT_MID_LO = 0;

	typedef enum logic [2:0] {
		ES_IDLE,
		ES_LOOKUP,
		ES_WAIT,
		ES_HEADER,
		ES_TRANS,
		ES_DISCARD
	} engine_state_t;

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_WRITE,
		CS_READ,
		CS_WAIT,
		CS_ACK
	} cfg_state_t;

endpackage

//--- logic/sync_fifo.sv
// show-ahead register FIFO; writes while full are dropped and reads while empty are ignored
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int ALF_LEVEL = 12
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [WIDTH-1:0] din,
	input logic rd,
	output logic [WIDTH-1:0] dout,
	output logic empty,
	output logic alf
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] fill;
	logic full;
	logic push;
	logic pop;

	// wraps at DEPTH, so any depth works
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (fill == CW'(DEPTH));
	assign empty = (fill == '0);
	assign alf = (fill >= CW'(ALF_LEVEL));
	assign push = wr && !full;
	assign pop = rd && !empty;
	assign dout = mem[rd_ptr]; // head entry, no read latency

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (push && !pop) begin
				fill <= fill + 1'b1;
			end else if (pop && !push) begin
				fill <= fill - 1'b1;
			end
		end
	end

endmodule

//--- logic/action_table_cfg.sv
// bus write and engine read of one entry in the same cycle return the old word to the engine
`timescale 1ns/100ps

module action_table_cfg
	import gac_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cs,
	input logic rw, // 0 write, 1 read
	input logic [15:0] addr,
	input act_word_t wdata,
	input logic in_valid_wr,
	input logic in_md_wr,
	input logic out_valid_wr,
	input tbl_addr_t tbl_addr,
	output logic ack,
	output act_word_t rdata,
	output act_word_t act_word
);

	act_word_t tbl [256];
	act_word_t cfg_q; // bus side read data
	act_word_t eng_q; // engine side, first stage
	cfg_state_t state;
	tbl_addr_t cfg_addr;
	logic cfg_tbl; // access targets the table
	logic cs_meta;
	logic cs_sync;
	logic tbl_we;
	count_t in_pkt_cnt;
	count_t in_md_cnt;
	count_t out_pkt_cnt;
	count_t cnt_sel;

	// ******************************
	// cs synchronizer
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_meta <= 1'b0;
			cs_sync <= 1'b0;
		end else begin
			cs_meta <= cs;
			cs_sync <= cs_meta;
		end
	end

	// write goes straight in on the edge that sees cs
	assign tbl_we = (state == CS_IDLE) && cs_sync && !rw && !addr[10];

	always_ff @(posedge clk) begin
		if (tbl_we) begin
			tbl[addr[9:2]] <= wdata;
		end
		cfg_q <= tbl[cfg_addr];
		eng_q <= tbl[tbl_addr];
		act_word <= eng_q; // 2 cycle engine latency
	end

	always_comb begin
		case (cfg_addr)
			8'd3: cnt_sel = in_pkt_cnt;
			8'd5: cnt_sel = in_md_cnt;
			8'd9: cnt_sel = out_pkt_cnt;
			default: cnt_sel = '0;
		endcase
	end

	// ******************************
	// bus state machine
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CS_IDLE;
			ack <= 1'b0;
			rdata <= '0;
			cfg_addr <= '0;
			cfg_tbl <= 1'b0;
		end else begin
			case (state)
				CS_IDLE: begin
					ack <= 1'b0;
					if (cs_sync) begin
						cfg_addr <= addr[9:2];
						cfg_tbl <= !addr[10];
						if (rw) begin
							state <= CS_READ;
						end else begin
							ack <= 1'b1; // entry committed this edge
							state <= CS_WRITE;
						end
					end
				end
				CS_WRITE: state <= CS_ACK;
				CS_READ: state <= CS_WAIT; // cfg_q loads from cfg_addr
				CS_WAIT: begin
					rdata <= cfg_tbl ? cfg_q : cnt_sel;
					ack <= 1'b1;
					state <= CS_ACK;
				end
				CS_ACK: begin
					if (!cs_sync) begin // master released cs
						ack <= 1'b0;
						state <= CS_IDLE;
					end
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

	// statistics
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_pkt_cnt <= '0;
			in_md_cnt <= '0;
			out_pkt_cnt <= '0;
		end else begin
			if (in_valid_wr) begin
				in_pkt_cnt <= in_pkt_cnt + 1'b1;
			end
			if (in_md_wr) begin
				in_md_cnt <= in_md_cnt + 1'b1;
			end
			if (out_valid_wr) begin
				out_pkt_cnt <= out_pkt_cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/action_engine.sv
// packets are at least two words; out_alf is checked only at packet start, so the sink must take a whole packet
`timescale 1ns/100ps
`include "gac_config.svh"

module action_engine
	import gac_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input cpuid_t sys_max_cpuid,
	input logic in_valid_wr,
	input pkt_word_t pkt_head,
	input logic pkt_empty,
	input md_t md_head,
	input logic md_empty,
	input act_word_t act_word,
	input logic out_alf,
	output logic pkt_rd,
	output logic md_rd,
	output tbl_addr_t tbl_addr,
	output pkt_word_t out_data,
	output logic out_data_wr,
	output logic out_valid_wr
);

	localparam int PW = $clog2(`GAC_PKT_DEPTH) + 1;

	engine_state_t state;
	engine_state_t state_nxt;
	logic [PW-1:0] pend_cnt; // complete packets in the fifo
	cpuid_t rr_id;
	logic [6:0] rr_step;
	logic [3:0] act_type;
	logic local_md;
	logic start;
	logic is_tail;
	logic hdr_pass; // header word goes out
	pkt_word_t hdr_word;
	pkt_word_t data_nxt;
	logic wr_nxt;
	logic valid_nxt;

	assign act_type = act_word[ACT_TYPE_HI:ACT_TYPE_LO];
	assign local_md = (md_head[MID_HI:MID_LO] == mid_t'(`GAC_LMID));
	assign start = (pend_cnt != '0) && !md_empty && !pkt_empty && !out_alf;
	assign is_tail = (pkt_head[TAG_HI:TAG_LO] == TAG_TAIL);
	assign rr_step = {1'b0, rr_id} + 7'd1;

	// ******************************
	// header rewrite
	// ******************************
	always_comb begin
		hdr_word = {pkt_head[FLG_HI:FLG_LO], md_head[FLG_LO-1:0]};
		hdr_pass = 1'b1;
		case (act_type)
			4'd1, 4'd2: begin // to a cpu thread
				hdr_word[PKT_DST] = 1'b1;
				hdr_word[OUT_TYPE_HI:OUT_TYPE_LO] = 2'd1;
				hdr_word[OUT_PORT_HI:OUT_PORT_LO] = (act_type == 4'd2) ? rr_id :
					act_word[ACT_PORT_HI:ACT_PORT_LO];
				hdr_word[MID_HI:MID_LO] = mid_t'(`GAC_NMID);
			end
			4'd3: begin // to a physical port
				hdr_word[PKT_DST] = 1'b0;
				hdr_word[OUT_TYPE_HI:OUT_TYPE_LO] = 2'd0;
				hdr_word[OUT_PORT_HI:OUT_PORT_LO] = act_word[ACT_PORT_HI:ACT_PORT_LO];
				hdr_word[MID_HI:MID_LO] = mid_t'(`GAC_NMID);
			end
			4'd4: begin // out port stays from metadata
				hdr_word[PKT_DST] = 1'b1;
				hdr_word[OUT_TYPE_HI:OUT_TYPE_LO] = 2'd0;
				hdr_word[MID_HI:MID_LO] = act_word[ACT_MID_HI:ACT_MID_LO];
			end
			default: begin
				// no action: only cpu sourced packets survive
				hdr_word = pkt_head;
				hdr_word[MID_HI:MID_LO] = mid_t'(`GAC_PASS_MID);
				hdr_pass = pkt_head[CPU_SRC];
			end
		endcase
	end

	// ******************************
	// packet state machine
	// ******************************
	always_comb begin
		state_nxt = state;
		pkt_rd = 1'b0;
		md_rd = 1'b0;
		wr_nxt = 1'b0;
		valid_nxt = 1'b0;
		data_nxt = pkt_head;
		case (state)
			ES_IDLE: begin
				if (start) begin
					if (local_md) begin
						state_nxt = ES_LOOKUP;
					end else begin
						md_rd = 1'b1; // other module, pass as is
						state_nxt = ES_TRANS;
					end
				end
			end
			ES_LOOKUP: state_nxt = ES_WAIT;
			ES_WAIT: state_nxt = ES_HEADER; // act_word valid next cycle
			ES_HEADER: begin
				pkt_rd = 1'b1;
				md_rd = 1'b1;
				data_nxt = hdr_word;
				wr_nxt = hdr_pass;
				state_nxt = hdr_pass ? ES_TRANS : ES_DISCARD;
			end
			ES_TRANS: begin
				if (!pkt_empty) begin
					pkt_rd = 1'b1;
					wr_nxt = 1'b1;
					valid_nxt = is_tail;
					if (is_tail) begin
						state_nxt = ES_IDLE;
					end
				end
			end
			ES_DISCARD: begin
				if (!pkt_empty) begin
					pkt_rd = 1'b1; // drop one word per cycle
					if (is_tail) begin
						state_nxt = ES_IDLE;
					end
				end
			end
			default: state_nxt = ES_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ES_IDLE;
			pend_cnt <= '0;
			rr_id <= '0;
			tbl_addr <= '0;
			out_data_wr <= 1'b0;
			out_valid_wr <= 1'b0;
		end else begin
			state <= state_nxt;
			out_data_wr <= wr_nxt;
			out_valid_wr <= valid_nxt;
			if (state == ES_IDLE) begin
				tbl_addr <= md_head[MD_IDX_HI:MD_IDX_LO];
			end
			if (in_valid_wr && !(state == ES_IDLE && start)) begin
				pend_cnt <= pend_cnt + 1'b1;
			end else if (!in_valid_wr && state == ES_IDLE && start) begin
				pend_cnt <= pend_cnt - 1'b1;
			end
			if (state == ES_HEADER && act_type == 4'd2) begin
				// wrap before reaching sys_max_cpuid
				rr_id <= (rr_step < {1'b0, sys_max_cpuid}) ? rr_step[5:0] : '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		out_data <= data_nxt;
	end

endmodule

//--- logic/gac_top.sv
// the sender must stop on data_alf and md_alf; in_valid_wr pulses once after each tail word
`timescale 1ns/100ps
`include "gac_config.svh"

module gac_top
	import gac_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input cpuid_t sys_max_cpuid,
	input pkt_word_t in_data,
	input logic in_data_wr,
	input logic in_valid_wr,
	input md_t in_md,
	input logic in_md_wr,
	input logic out_alf,
	input logic cs,
	input logic rw,
	input logic [15:0] addr,
	input act_word_t wdata,
	output logic data_alf,
	output logic md_alf,
	output pkt_word_t out_data,
	output logic out_data_wr,
	output logic out_valid_wr,
	output logic ack,
	output act_word_t rdata
);

	pkt_word_t pkt_head;
	md_t md_head;
	logic pkt_rd;
	logic md_rd;
	logic pkt_empty;
	logic md_empty;
	tbl_addr_t tbl_addr;
	act_word_t act_word;

	// ******************************
	// input fifos
	// ******************************
	sync_fifo #(
		.WIDTH(`GAC_PKT_W),
		.DEPTH(`GAC_PKT_DEPTH),
		.ALF_LEVEL(`GAC_PKT_ALF_LEVEL)
	) pkt_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(in_data_wr),
		.din(in_data),
		.rd(pkt_rd),
		.dout(pkt_head),
		.empty(pkt_empty),
		.alf(data_alf)
	);

	sync_fifo #(
		.WIDTH(`GAC_MD_W),
		.DEPTH(`GAC_MD_DEPTH),
		.ALF_LEVEL(`GAC_MD_ALF_LEVEL)
	) md_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(in_md_wr),
		.din(in_md),
		.rd(md_rd),
		.dout(md_head),
		.empty(md_empty),
		.alf(md_alf)
	);

	action_table_cfg u_table (
		.clk(clk),
		.rst_n(rst_n),
		.cs(cs),
		.rw(rw),
		.addr(addr),
		.wdata(wdata),
		.in_valid_wr(in_valid_wr),
		.in_md_wr(in_md_wr),
		.out_valid_wr(out_valid_wr),
		.tbl_addr(tbl_addr),
		.ack(ack),
		.rdata(rdata),
		.act_word(act_word)
	);

	action_engine u_engine (
		.clk(clk),
		.rst_n(rst_n),
		.sys_max_cpuid(sys_max_cpuid),
		.in_valid_wr(in_valid_wr),
		.pkt_head(pkt_head),
		.pkt_empty(pkt_empty),
		.md_head(md_head),
		.md_empty(md_empty),
		.act_word(act_word),
		.out_alf(out_alf),
		.pkt_rd(pkt_rd),
		.md_rd(md_rd),
		.tbl_addr(tbl_addr),
		.out_data(out_data),
		.out_data_wr(out_data_wr),
		.out_valid_wr(out_valid_wr)
	);

endmodule

//--- tb/gac_chk.sv
// checks assume the bus master drops cs only after ack, and never raises cs again before ack falls
`timescale 1ns/100ps

module gac_chk
	import gac_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cs,
	input logic ack,
	input pkt_word_t out_data,
	input logic out_data_wr,
	input logic out_valid_wr
);

	// ******************************
	// output stream
	// ******************************
	a_valid_on_tail: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_wr |-> (out_data_wr && out_data[TAG_HI:TAG_LO] == TAG_TAIL))
		else $error("out_valid_wr without a tail word on out_data");

	a_wr_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_data_wr) && !$isunknown(out_valid_wr))
		else $error("output strobes unknown after reset");

	// ******************************
	// local bus
	// ******************************
	// two sync flops plus the state update, so ack is gone by the fourth sample
	a_ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(!cs && $past(!cs, 1) && $past(!cs, 2) && $past(!cs, 3)) |-> !ack)
		else $error("ack still high after cs was released");

endmodule

//--- tb/gac_tb.sv
// table contents come only from the bus writes made here; sys_max_cpuid stays at 3 and out_alf low
`timescale 1ns/100ps
`include "gac_config.svh"

module gac_tb
	import gac_pkg::*;
();

	localparam int N_PKT = 12;
	localparam int N_BUS = 17;

	logic clk;
	logic rst_n;
	cpuid_t sys_max_cpuid;
	pkt_word_t in_data;
	logic in_data_wr;
	logic in_valid_wr;
	md_t in_md;
	logic in_md_wr;
	logic out_alf;
	logic cs;
	logic rw;
	logic [15:0] addr;
	act_word_t wdata;
	logic data_alf;
	logic md_alf;
	pkt_word_t out_data;
	logic out_data_wr;
	logic out_valid_wr;
	logic ack;
	act_word_t rdata;

	logic [15:0] lfsr_state;
	act_word_t tbl_model [256];
	cpuid_t rr_model;
	pkt_word_t exp_q [$];
	int err_cnt;
	int misc_cnt;
	int pkt_sent;
	int md_sent;
	int pkt_expected;

	gac_top uut (.*);

	bind gac_top gac_chk chk (
		.clk(clk),
		.rst_n(rst_n),
		.cs(cs),
		.ack(ack),
		.out_data(out_data),
		.out_data_wr(out_data_wr),
		.out_valid_wr(out_valid_wr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ******************************
	// random source
	// ******************************
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // maximal 16 bit taps
	endfunction

	function automatic logic [255:0] rand_bits(input int n);
		logic [255:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[254:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int pkt_len();
		logic [255:0] r;
		r = rand_bits(3);
		return 2 + (r[2:0] % 5); // 2 to 6 words
	endfunction

	// expected header word; keep is low when the packet must vanish
	function automatic pkt_word_t ref_header(input pkt_word_t head, input md_t md,
			output logic keep);
		act_word_t act;
		pkt_word_t h;
		int nxt;
		keep = 1'b1;
		if (md[MID_HI:MID_LO] != mid_t'(`GAC_LMID)) begin
			return head; // not ours
		end
		act = tbl_model[md[MD_IDX_HI:MD_IDX_LO]];
		h = {head[FLG_HI:FLG_LO], md[FLG_LO-1:0]};
		case (act[ACT_TYPE_HI:ACT_TYPE_LO])
			4'd1, 4'd2: begin
				h[PKT_DST] = 1'b1;
				h[OUT_TYPE_HI:OUT_TYPE_LO] = 2'd1;
				h[OUT_PORT_HI:OUT_PORT_LO] = act[ACT_PORT_HI:ACT_PORT_LO];
				h[MID_HI:MID_LO] = mid_t'(`GAC_NMID);
				if (act[ACT_TYPE_HI:ACT_TYPE_LO] == 4'd2) begin
					h[OUT_PORT_HI:OUT_PORT_LO] = rr_model;
					nxt = int'(rr_model) + 1;
					rr_model = (nxt >= int'(sys_max_cpuid)) ? '0 : cpuid_t'(nxt);
				end
			end
			4'd3: begin
				h[PKT_DST] = 1'b0;
				h[OUT_TYPE_HI:OUT_TYPE_LO] = 2'd0;
				h[OUT_PORT_HI:OUT_PORT_LO] = act[ACT_PORT_HI:ACT_PORT_LO];
				h[MID_HI:MID_LO] = mid_t'(`GAC_NMID);
			end
			4'd4: begin
				h[PKT_DST] = 1'b1;
				h[OUT_TYPE_HI:OUT_TYPE_LO] = 2'd0;
				h[MID_HI:MID_LO] = act[ACT_MID_HI:ACT_MID_LO];
			end
			default: begin
				h = head;
				h[MID_HI:MID_LO] = mid_t'(`GAC_PASS_MID);
				keep = head[CPU_SRC];
			end
		endcase
		return h;
	endfunction

	// ******************************
	// compare tasks
	// ******************************
	task automatic check_pkt_word(input string name, input pkt_word_t exp, input pkt_word_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_act_word(input string name, input act_word_t exp, input act_word_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// ******************************
	// bus and packet drivers
	// ******************************
	task automatic bus_access(input logic rd, input logic [15:0] a, input act_word_t d,
			output act_word_t q);
		@(posedge clk);
		rw <= rd;
		addr <= a;
		wdata <= d;
		cs <= 1'b1;
		do @(posedge clk); while (ack !== 1'b1);
		q = rdata;
		cs <= 1'b0;
		do @(posedge clk); while (ack !== 1'b0); // ack low before next access
	endtask

	task automatic send_packet(input mid_t md_mid, input tbl_addr_t idx, input logic cpu_src);
		md_t md;
		pkt_word_t words [6];
		pkt_word_t hdr;
		logic [255:0] r;
		logic keep;
		int len;
		int i;
		len = pkt_len();
		md = rand_bits(256);
		md[MID_HI:MID_LO] = md_mid;
		md[MD_IDX_HI:MD_IDX_LO] = idx;
		for (i = 0; i < len; i++) begin
			r = rand_bits(132);
			words[i] = {TAG_MID, r[131:0]};
			if (i == 0) begin
				words[i][TAG_HI:TAG_LO] = TAG_HEAD;
			end else if (i == len - 1) begin
				words[i][TAG_HI:TAG_LO] = TAG_TAIL;
			end
		end
		words[0][CPU_SRC] = cpu_src;
		hdr = ref_header(words[0], md, keep);
		if (keep) begin
			exp_q.push_back(hdr);
			for (i = 1; i < len; i++) begin
				exp_q.push_back(words[i]);
			end
			pkt_expected++;
		end
		@(posedge clk);
		while (data_alf || md_alf) @(posedge clk);
		in_md <= md;
		in_md_wr <= 1'b1;
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			in_md_wr <= 1'b0;
			in_data <= words[i];
			in_data_wr <= 1'b1;
		end
		@(posedge clk);
		in_data_wr <= 1'b0;
		in_valid_wr <= 1'b1; // packet complete
		@(posedge clk);
		in_valid_wr <= 1'b0;
		pkt_sent++;
		md_sent++;
	endtask

	always @(posedge clk) begin : compare
		pkt_word_t exp_w;
		if (rst_n) begin
			// traffic here stays far below both almost-full levels
			check_flag("data_alf", 1'b0, data_alf);
			check_flag("md_alf", 1'b0, md_alf);
		end
		if (rst_n && out_data_wr === 1'b1) begin
			if (exp_q.size() == 0) begin
				misc_cnt++;
				$display("output word at %0t ns while no word was expected", $time);
			end else begin
				exp_w = exp_q.pop_front();
				check_pkt_word("out_data", exp_w, out_data);
				check_flag("out_valid_wr", exp_w[TAG_HI:TAG_LO] == TAG_TAIL, out_valid_wr);
			end
		end
	end

	// ******************************
	// test sequence
	// ******************************
	initial begin : main
		tbl_addr_t idx [6];
		logic [3:0] types [6];
		act_word_t act;
		act_word_t q;
		logic [255:0] r;
		int k;
		rst_n = 1'b0;
		sys_max_cpuid = 6'd3;
		in_data = '0;
		in_data_wr = 1'b0;
		in_valid_wr = 1'b0;
		in_md = '0;
		in_md_wr = 1'b0;
		out_alf = 1'b0;
		cs = 1'b0;
		rw = 1'b0;
		addr = '0;
		wdata = '0;
		lfsr_state = 16'd35;
		rr_model = '0;
		err_cnt = 0;
		misc_cnt = 0;
		pkt_sent = 0;
		md_sent = 0;
		pkt_expected = 0;
		types = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd9, 4'd0}; // 9 and 0 have no action
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (k = 0; k < 6; k++) begin
			r = rand_bits(33);
			idx[k] = {r[32:28], 3'(k)}; // low bits keep entries apart
			act = {types[k], r[27:0]};
			tbl_model[idx[k]] = act;
			bus_access(1'b0, {6'd0, idx[k], 2'd0}, act, q);
		end
		for (k = 0; k < 6; k++) begin
			bus_access(1'b1, {6'd0, idx[k], 2'd0}, '0, q);
			check_act_word("rdata", tbl_model[idx[k]], q);
		end

		r = rand_bits(5);
		send_packet(mid_t'(`GAC_LMID), idx[0], r[0]);
		send_packet(mid_t'(`GAC_LMID), idx[2], r[1]);
		send_packet(mid_t'(`GAC_LMID), idx[3], r[2]);
		for (k = 0; k < 4; k++) begin
			send_packet(mid_t'(`GAC_LMID), idx[1], r[3]); // ports 0 1 2 0
		end
		send_packet(mid_t'(`GAC_LMID), idx[4], 1'b1);
		send_packet(mid_t'(`GAC_LMID), idx[5], 1'b0); // dropped
		send_packet(mid_t'(`GAC_LMID), idx[0], r[4]);
		send_packet(8'h09, idx[2], r[0]);
		send_packet(8'h2c, idx[1], r[1]);

		while (exp_q.size() != 0) @(posedge clk);
		bus_access(1'b1, {5'd0, 1'b1, 8'd3, 2'd0}, '0, q);
		check_count("in_pkt_cnt", count_t'(pkt_sent), q);
		bus_access(1'b1, {5'd0, 1'b1, 8'd5, 2'd0}, '0, q);
		check_count("in_md_cnt", count_t'(md_sent), q);
		bus_access(1'b1, {5'd0, 1'b1, 8'd9, 2'd0}, '0, q);
		check_count("out_pkt_cnt", count_t'(pkt_expected), q);
		// unused counter slots, read while all counters are nonzero
		bus_access(1'b1, {5'd0, 1'b1, 8'd7, 2'd0}, '0, q);
		check_count("rdata", '0, q);
		bus_access(1'b1, {5'd0, 1'b1, 8'd0, 2'd0}, '0, q);
		check_count("rdata", '0, q);

		$display("errors: %0d value mismatches, %0d other failures", err_cnt, misc_cnt);
		if (err_cnt == 0 && misc_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (N_PKT * 200 + N_BUS * 20) @(posedge clk);
		$display("timeout: traffic or bus access did not complete in time");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- files.f
+incdir+logic
logic/gac_pkg.sv
logic/sync_fifo.sv
logic/action_table_cfg.sv
logic/action_engine.sv
logic/gac_top.sv
tb/gac_chk.sv
tb/gac_tb.sv
